// ==== logic/dbus_defines.svh ====
`ifndef DBUS_DEFINES_SVH
`define DBUS_DEFINES_SVH

// Data and address width
`define XLEN 32

// Data memory, word addressed
`define DMEM_WORDS 1024
`define DMEM_BASE 32'h0000_0000

// GPIO block
`define GPIO_BASE 32'h0000_2000
`define GPIO_W 8

`endif

// ==== logic/dbus_pkg.sv ====
`include "dbus_defines.svh"

package dbus_pkg;

  // Load/store operations from the core
  typedef enum logic [2:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } mem_op_e;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESP
  } ctrl_state_e;

  // Core side request, byte address
  typedef struct packed {
    mem_op_e           op;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
  } mem_req_s;

  typedef struct packed {
    logic [`XLEN-1:0] rdata;
    logic             err;    // Misaligned or unmapped
  } mem_rsp_s;

  // Internal bus request, word address
  typedef struct packed {
    logic             cyc;
    logic             we;
    logic [3:0]       byte_en;
    logic [`XLEN-3:0] addr;
    logic [`XLEN-1:0] wdata;
  } dbus_req_s;

  typedef struct packed {
    logic [`XLEN-1:0] rdata;
  } peri_rsp_s;

endpackage

// ==== logic/lsu_align.sv ====
`timescale 1ns/1ps

module lsu_align import dbus_pkg::*; (
  input  mem_op_e     st_op,
  input  logic [1:0]  st_offset,
  input  logic [31:0] st_data,
  output logic [3:0]  st_byte_en,
  output logic [31:0] st_wdata,
  input  mem_op_e     ld_op,
  input  logic [1:0]  ld_offset,
  input  logic [31:0] ld_raw,
  output logic [31:0] ld_data
);

  logic [31:0] ld_shift;

  // Store lanes: replicate the value, enables pick the lane
  always_comb begin
    case (st_op)
      SB: begin
        st_byte_en = 4'b0001 << st_offset;
        st_wdata   = {4{st_data[7:0]}};
      end
      SH: begin
        st_byte_en = st_offset[1] ? 4'b1100 : 4'b0011;
        st_wdata   = {2{st_data[15:0]}};
      end
      SW: begin
        st_byte_en = 4'b1111;
        st_wdata   = st_data;
      end
      default: begin
        st_byte_en = 4'b0000;  // Loads write nothing
        st_wdata   = st_data;
      end
    endcase
  end

  // Addressed lane moved down to bit 0
  assign ld_shift = ld_raw >> {ld_offset, 3'b000};

  always_comb begin
    case (ld_op)
      LB:      ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
      LBU:     ld_data = {24'h00_0000, ld_shift[7:0]};
      LH:      ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
      LHU:     ld_data = {16'h0000, ld_shift[15:0]};
      LW:      ld_data = ld_raw;
      default: ld_data = '0;     // Stores return zero
    endcase
  end

endmodule

// ==== logic/data_mem.sv ====
`timescale 1ns/1ps
`include "dbus_defines.svh"

module data_mem import dbus_pkg::*; (
  input  logic      clk,
  input  logic      sel,
  input  dbus_req_s bus,
  output peri_rsp_s rsp
);

  localparam int          AW   = $clog2(`DMEM_WORDS);
  localparam logic [31:0] BASE = `DMEM_BASE;

  logic [`XLEN-1:0] mem [`DMEM_WORDS];
  logic [`XLEN-3:0] word_off;
  logic [AW-1:0]    idx;
  logic [`XLEN-1:0] rdata_q;

  // Word offset from the memory base
  assign word_off = bus.addr - BASE[31:2];
  assign idx      = word_off[AW-1:0];

  always_ff @(posedge clk) begin
    if (sel && bus.cyc && bus.we) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.byte_en[b])
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
    if (sel)
      rdata_q <= mem[idx];  // Old word on a store cycle
  end

  assign rsp.rdata = rdata_q;

  // Decoder must never select the memory out of range
  a_in_range: assert property (@(posedge clk) sel |-> word_off < `DMEM_WORDS);

endmodule

// ==== logic/gpio_regs.sv ====
`timescale 1ns/1ps
`include "dbus_defines.svh"

module gpio_regs import dbus_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               sel,
  input  dbus_req_s          bus,
  output peri_rsp_s          rsp,
  input  logic [`GPIO_W-1:0] gpio_in,
  output logic [`GPIO_W-1:0] gpio_out
);

  localparam int PAD = `XLEN - `GPIO_W;

  logic [`GPIO_W-1:0] out_q;
  logic [`GPIO_W-1:0] dir_q;
  logic [`GPIO_W-1:0] in_q;
  logic [`XLEN-1:0]   rdata_q;
  logic               wr;

  // Only byte lane 0 carries register data
  assign wr = sel && bus.cyc && bus.we && bus.byte_en[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (wr) begin
      case (bus.addr[1:0])
        2'd0:    out_q <= bus.wdata[`GPIO_W-1:0];
        2'd2:    dir_q <= bus.wdata[`GPIO_W-1:0];
        default: ;  // Input register is read only
      endcase
    end
  end

  always_ff @(posedge clk) begin
    in_q <= gpio_in;  // Sampled every cycle
    if (sel) begin
      case (bus.addr[1:0])
        2'd0:    rdata_q <= {{PAD{1'b0}}, out_q};
        2'd1:    rdata_q <= {{PAD{1'b0}}, in_q};
        2'd2:    rdata_q <= {{PAD{1'b0}}, dir_q};
        default: rdata_q <= '0;
      endcase
    end
  end

  assign rsp.rdata = rdata_q;
  assign gpio_out  = out_q & dir_q;  // Drive only pins set as outputs

endmodule

// ==== logic/dbus_ctrl.sv ====
`timescale 1ns/1ps
`include "dbus_defines.svh"

module dbus_ctrl import dbus_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_valid,
  input  mem_req_s    req,
  output logic        req_ready,
  output logic        resp_valid,
  output mem_rsp_s    resp,
  input  logic        resp_ready,
  output dbus_req_s   bus,
  output logic        mem_sel,
  output logic        gpio_sel,
  input  peri_rsp_s   mem_rsp,
  input  peri_rsp_s   gpio_rsp,
  input  logic [3:0]  st_byte_en,
  input  logic [31:0] st_wdata,
  output logic [31:0] ld_raw,
  output mem_op_e     ld_op,
  output logic [1:0]  ld_offset,
  input  logic [31:0] ld_data
);

  localparam logic [31:0] MEM_LO    = `DMEM_BASE;
  localparam logic [31:0] MEM_BYTES = `DMEM_WORDS * 4;
  localparam logic [31:0] GPIO_LO   = `GPIO_BASE;

  ctrl_state_e state_q;
  logic        resp_valid_q;
  mem_op_e     op_q;
  logic [31:0] addr_q;
  logic [3:0]  be_q;
  logic [31:0] wdata_q;
  logic [31:0] ld_raw_q;
  logic        cyc;
  logic        is_store;
  logic        mem_hit;
  logic        gpio_hit;
  logic        misaligned;
  logic        err;

  assign req_ready = (state_q == IDLE);
  assign cyc       = (state_q == ACCESS);

  // Address decode on the held request
  assign mem_hit  = (addr_q >= MEM_LO) && ((addr_q - MEM_LO) < MEM_BYTES);
  assign gpio_hit = (addr_q[31:4] == GPIO_LO[31:4]) && (addr_q[3:2] != 2'b11);
  assign is_store = op_q inside {SB, SH, SW};

  always_comb begin
    case (op_q)
      LH, LHU, SH: misaligned = addr_q[0];
      LW, SW:      misaligned = |addr_q[1:0];
      default:     misaligned = 1'b0;
    endcase
  end

  assign err = misaligned || !(mem_hit || gpio_hit);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      resp_valid_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE:   if (req_valid) state_q <= ACCESS;
        ACCESS: state_q <= RESP;
        RESP: begin
          if (!resp_valid_q) begin
            resp_valid_q <= 1'b1;  // Slave data was registered last edge
          end else if (resp_ready) begin
            resp_valid_q <= 1'b0;
            state_q      <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request payload and returned word
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      op_q    <= req.op;
      addr_q  <= req.addr;
      be_q    <= st_byte_en;
      wdata_q <= st_wdata;
    end
    if (state_q == RESP && !resp_valid_q)
      ld_raw_q <= mem_hit ? mem_rsp.rdata : (gpio_hit ? gpio_rsp.rdata : '0);
  end

  assign bus.cyc     = cyc;
  assign bus.we      = cyc && is_store && !err;
  assign bus.byte_en = be_q;
  assign bus.addr    = addr_q[31:2];
  assign bus.wdata   = wdata_q;

  assign mem_sel  = cyc && mem_hit && !err;
  assign gpio_sel = cyc && gpio_hit && !err;

  assign ld_raw    = ld_raw_q;
  assign ld_op     = op_q;
  assign ld_offset = addr_q[1:0];

  assign resp_valid = resp_valid_q;
  assign resp.rdata = err ? '0 : ld_data;
  assign resp.err   = err;

  // Response held until the core takes it
  a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp));

  a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_sel && gpio_sel));

endmodule

// ==== logic/dbus_top.sv ====
`timescale 1ns/1ps
`include "dbus_defines.svh"

module dbus_top import dbus_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid,
  input  mem_req_s           req,
  output logic               req_ready,
  output logic               resp_valid,
  output mem_rsp_s           resp,
  input  logic               resp_ready,
  input  logic [`GPIO_W-1:0] gpio_in,
  output logic [`GPIO_W-1:0] gpio_out
);

  dbus_req_s   bus;
  logic        mem_sel;
  logic        gpio_sel;
  peri_rsp_s   mem_rsp;
  peri_rsp_s   gpio_rsp;
  logic [3:0]  st_byte_en;
  logic [31:0] st_wdata;
  logic [31:0] ld_raw;
  mem_op_e     ld_op;
  logic [1:0]  ld_offset;
  logic [31:0] ld_data;

  dbus_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_ready (resp_ready),
    .bus        (bus),
    .mem_sel    (mem_sel),
    .gpio_sel   (gpio_sel),
    .mem_rsp    (mem_rsp),
    .gpio_rsp   (gpio_rsp),
    .st_byte_en (st_byte_en),
    .st_wdata   (st_wdata),
    .ld_raw     (ld_raw),
    .ld_op      (ld_op),
    .ld_offset  (ld_offset),
    .ld_data    (ld_data)
  );

  // Store side works on the incoming request, captured at acceptance
  lsu_align u_align (
    .st_op      (req.op),
    .st_offset  (req.addr[1:0]),
    .st_data    (req.wdata),
    .st_byte_en (st_byte_en),
    .st_wdata   (st_wdata),
    .ld_op      (ld_op),
    .ld_offset  (ld_offset),
    .ld_raw     (ld_raw),
    .ld_data    (ld_data)
  );

  data_mem u_mem (
    .clk (clk),
    .sel (mem_sel),
    .bus (bus),
    .rsp (mem_rsp)
  );

  gpio_regs u_gpio (
    .clk      (clk),
    .rst_n    (rst_n),
    .sel      (gpio_sel),
    .bus      (bus),
    .rsp      (gpio_rsp),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

endmodule

// ==== test/dbus_tb.sv ====
`timescale 1ns/1ps
`include "dbus_defines.svh"

module dbus_tb import dbus_pkg::*; ();

  localparam int TIMEOUT = 50;  // Cycles allowed for any single wait

  // One table row with request, pin input and expected response
  typedef struct packed {
    mem_op_e            op;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    logic [`GPIO_W-1:0] gpio_in;
    logic [31:0]        exp_rdata;
    logic               exp_err;
  } entry_s;

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  mem_req_s           req;
  logic               req_ready;
  logic               resp_valid;
  mem_rsp_s           resp;
  logic               resp_ready;
  logic [`GPIO_W-1:0] gpio_in;
  logic [`GPIO_W-1:0] gpio_out;

  entry_s     tbl [$];
  logic [7:0] lfsr_q;
  int         errors;
  int         timeouts;

  dbus_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_ready (resp_ready),
    .gpio_in    (gpio_in),
    .gpio_out   (gpio_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // 8-bit Fibonacci LFSR with taps 8 6 5 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic rand_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);  // One step per bit
      val    = (val << 1) | lfsr_q[0];
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Drive and sample away from the edge
  endtask

  task automatic add_entry(input mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [`GPIO_W-1:0] gin,
                           input logic [31:0] exp_rdata, input logic exp_err);
    entry_s e;
    e.op        = op;
    e.addr      = addr;
    e.wdata     = wdata;
    e.gpio_in   = gin;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    // Word stores answer with zero before readback
    add_entry(SW,  32'h0000, 32'hDEAD_BEEF, 8'h00, 32'h0000_0000, 1'b0);
    add_entry(SW,  32'h0004, 32'h1234_5678, 8'h00, 32'h0000_0000, 1'b0);
    add_entry(SW,  32'h0FFC, 32'hCAFE_F00D, 8'h00, 32'h0000_0000, 1'b0);
    add_entry(SW,  32'h0100, 32'h1122_3344, 8'h00, 32'h0000_0000, 1'b0);
    add_entry(LW,  32'h0000, 32'h0,         8'h00, 32'hDEAD_BEEF, 1'b0);
    add_entry(LW,  32'h0004, 32'h0,         8'h00, 32'h1234_5678, 1'b0);
    add_entry(LW,  32'h0FFC, 32'h0,         8'h00, 32'hCAFE_F00D, 1'b0);
    // Byte and halfword merge into 0x11223344
    add_entry(SB,  32'h0101, 32'h0000_0080, 8'h00, 32'h0000_0000, 1'b0);
    add_entry(SH,  32'h0102, 32'h0000_F00D, 8'h00, 32'h0000_0000, 1'b0);
    add_entry(LW,  32'h0100, 32'h0,         8'h00, 32'hF00D_8044, 1'b0);
    add_entry(LB,  32'h0101, 32'h0,         8'h00, 32'hFFFF_FF80, 1'b0);
    add_entry(LBU, 32'h0101, 32'h0,         8'h00, 32'h0000_0080, 1'b0);
    add_entry(LB,  32'h0100, 32'h0,         8'h00, 32'h0000_0044, 1'b0);
    add_entry(LH,  32'h0102, 32'h0,         8'h00, 32'hFFFF_F00D, 1'b0);
    add_entry(LHU, 32'h0102, 32'h0,         8'h00, 32'h0000_F00D, 1'b0);
    add_entry(LH,  32'h0100, 32'h0,         8'h00, 32'hFFFF_8044, 1'b0);
    add_entry(SB,  32'h0103, 32'h0000_007F, 8'h00, 32'h0000_0000, 1'b0);
    add_entry(LB,  32'h0103, 32'h0,         8'h00, 32'h0000_007F, 1'b0);
    // GPIO registers
    add_entry(SW,  32'h2000, 32'h0000_00A5, 8'h3C, 32'h0000_0000, 1'b0);
    add_entry(SW,  32'h2008, 32'h0000_000F, 8'h3C, 32'h0000_0000, 1'b0);
    add_entry(LW,  32'h2000, 32'h0,         8'h3C, 32'h0000_00A5, 1'b0);
    add_entry(LW,  32'h2008, 32'h0,         8'h3C, 32'h0000_000F, 1'b0);
    add_entry(LW,  32'h2004, 32'h0,         8'h3C, 32'h0000_003C, 1'b0);
    add_entry(SW,  32'h2004, 32'h0000_00FF, 8'h5A, 32'h0000_0000, 1'b0);
    add_entry(LW,  32'h2004, 32'h0,         8'h5A, 32'h0000_005A, 1'b0);
    add_entry(LW,  32'h200C, 32'h0,         8'h5A, 32'h0000_0000, 1'b1);
    // Misaligned and unmapped accesses
    add_entry(LH,  32'h0005, 32'h0,         8'h00, 32'h0000_0000, 1'b1);
    add_entry(LW,  32'h0006, 32'h0,         8'h00, 32'h0000_0000, 1'b1);
    add_entry(SW,  32'h0002, 32'hFFFF_FFFF, 8'h00, 32'h0000_0000, 1'b1);
    add_entry(LW,  32'h0000, 32'h0,         8'h00, 32'hDEAD_BEEF, 1'b0);
    add_entry(LW,  32'h1000, 32'h0,         8'h00, 32'h0000_0000, 1'b1);
    add_entry(SW,  32'h1000, 32'h5555_AAAA, 8'h00, 32'h0000_0000, 1'b1);
    add_entry(SB,  32'h1000, 32'h0000_0011, 8'h00, 32'h0000_0000, 1'b1);
    add_entry(LW,  32'h0000, 32'h0,         8'h00, 32'hDEAD_BEEF, 1'b0);
  endtask

  task automatic apply_entry(input int idx, output logic timed_out);
    entry_s   e;
    mem_rsp_s held;
    int       gap;
    int       hold;
    int       waited;
    e         = tbl[idx];
    timed_out = 1'b0;
    gpio_in   = e.gpio_in;
    rand_bits(2, gap);
    rand_bits(2, hold);   // Cycles of resp_ready low
    repeat (gap) next_cycle();

    waited = 0;
    while (!req_ready && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!req_ready) begin
      $display("Timeout: req_ready never went high for entry %0d", idx);
      timed_out = 1'b1;
      return;
    end
    req_valid = 1'b1;
    req.op    = e.op;
    req.addr  = e.addr;
    req.wdata = e.wdata;
    next_cycle();         // Accepting edge
    req_valid = 1'b0;

    waited = 0;
    while (!resp_valid && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!resp_valid) begin
      $display("Timeout: no response for entry %0d", idx);
      timed_out = 1'b1;
      return;
    end
    assert (waited == 2) else begin
      $display("Entry %0d: response came %0d cycles after acceptance, not 2", idx, waited);
      errors++;
    end

    held = resp;
    for (int c = 0; c < hold; c++) begin
      next_cycle();
      assert (resp_valid) else begin
        $display("ERROR resp_valid: entry %0d got %h expected %h", idx, resp_valid, 1'b1);
        errors++;
      end
      assert (resp == held) else begin
        $display("ERROR resp: entry %0d got %h expected %h", idx, resp, held);
        errors++;
      end
      assert (!req_ready) else begin
        $display("ERROR req_ready: entry %0d got %h expected %h", idx, req_ready, 1'b0);
        errors++;
      end
    end

    assert (held.rdata == e.exp_rdata) else begin
      $display("ERROR resp.rdata: entry %0d got %h expected %h", idx, held.rdata, e.exp_rdata);
      errors++;
    end
    assert (held.err == e.exp_err) else begin
      $display("ERROR resp.err: entry %0d got %h expected %h", idx, held.err, e.exp_err);
      errors++;
    end

    resp_ready = 1'b1;
    next_cycle();         // Response taken here
    resp_ready = 1'b0;
    assert (!resp_valid) else begin
      $display("ERROR resp_valid: entry %0d got %h expected %h", idx, resp_valid, 1'b0);
      errors++;
    end
    assert (req_ready) else begin
      $display("ERROR req_ready: entry %0d got %h expected %h", idx, req_ready, 1'b1);
      errors++;
    end
  endtask

  initial begin
    logic timed_out;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b0;
    gpio_in    = '0;
    lfsr_q     = 8'd26;
    errors     = 0;
    timeouts   = 0;
    build_table();

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // State straight out of reset
    assert (req_ready) else begin
      $display("ERROR req_ready: got %h expected %h", req_ready, 1'b1);
      errors++;
    end
    assert (!resp_valid) else begin
      $display("ERROR resp_valid: got %h expected %h", resp_valid, 1'b0);
      errors++;
    end
    assert (gpio_out == '0) else begin
      $display("ERROR gpio_out: got %h expected %h", gpio_out, 8'h00);
      errors++;
    end

    for (int i = 0; i < tbl.size(); i++) begin
      apply_entry(i, timed_out);
      if (timed_out) begin
        timeouts++;
        break;
      end
    end

    if (timeouts == 0) begin
      assert (gpio_out == 8'h05) else begin  // 0xA5 masked by direction 0x0F
        $display("ERROR gpio_out: got %h expected %h", gpio_out, 8'h05);
        errors++;
      end
    end

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+logic
logic/dbus_pkg.sv
logic/lsu_align.sv
logic/data_mem.sv
logic/gpio_regs.sv
logic/dbus_ctrl.sv
logic/dbus_top.sv
test/dbus_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = dbus_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
